// ==== verilog/arcadeIoPkg.sv ====
package arcadeIoPkg;

  ////////////////////////////////////////////////////////////
  // Clock-enable divider
  ////////////////////////////////////////////////////////////
  localparam int cpuTickPeriod   = 16;
  localparam int cpuTickReload   = 8;
  localparam int soundTickPeriod = 8192;
  localparam int soundTickReload = 4096;
  localparam int nmiTickPeriod   = 16384;
  localparam int nmiTickReload   = 8192;

  // Counter widths give the wrap for free
  localparam int cpuCountWidth   = $clog2(cpuTickPeriod);
  localparam int soundCountWidth = $clog2(soundTickPeriod);
  localparam int nmiCountWidth   = $clog2(nmiTickPeriod);

  typedef logic [cpuCountWidth-1:0]   cpuCount_t;
  typedef logic [soundCountWidth-1:0] soundCount_t;
  typedef logic [nmiCountWidth-1:0]   nmiCount_t;

  // NMI cadence counted in interrupt ticks
  localparam int nmiCycleLength = 14;
  localparam int nmiAssertCount = 12;
  typedef logic [$clog2(nmiCycleLength)-1:0] nmiCycle_t;

  ////////////////////////////////////////////////////////////
  // CPU bus map
  ////////////////////////////////////////////////////////////
  localparam logic [15:0] bzLatchAddr       = 16'h1840;
  localparam logic [15:0] rbLatchAddr       = 16'h1808;
  localparam logic [15:0] bzPokeyBase       = 16'h1820;
  localparam logic [15:0] rbPokeyBase       = 16'h1810;
  localparam logic [15:0] tempestPokey0Base = 16'h60C0;
  localparam logic [15:0] tempestPokey1Base = 16'h60D0;
  // POKEY windows are 16 bytes
  localparam int pokeyWindowBits = 4;

  // Battlezone noise generator
  localparam int lfsrWidth   = 16;
  localparam int lfsrTapLow  = 3;
  localparam int lfsrTapHigh = 14;

  typedef enum logic [1:0] {modeBattlezone, modeRedBaron, modeTempest} gameMode_t;

  typedef struct packed {logic cpuTick; logic soundTick; logic nmiTick;} tickBus_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [7:0]  pwdata;
  } apbReq_t;

  typedef struct packed {logic pready; logic [7:0] prdata;} apbRsp_t;

  typedef struct packed {logic [7:0] bzLatch; logic [7:0] rbLatch;} latchBus_t;

endpackage

// ==== verilog/tickGenerator.sv ====
`timescale 1ns/1ps

module tickGenerator (
  input  logic                  clk,
  input  logic                  rst,
  output arcadeIoPkg::tickBus_t ticks
);

  arcadeIoPkg::cpuCount_t   cpuCount;
  arcadeIoPkg::soundCount_t soundCount;
  arcadeIoPkg::nmiCount_t   nmiCount;
  logic                     soundArmed;

  // Free-running counters preset during reset
  always_ff @(posedge clk) begin
    if (rst) begin
      cpuCount   <= arcadeIoPkg::cpuCount_t'(arcadeIoPkg::cpuTickReload);
      soundCount <= arcadeIoPkg::soundCount_t'(arcadeIoPkg::soundTickReload);
      nmiCount   <= arcadeIoPkg::nmiCount_t'(arcadeIoPkg::nmiTickReload);
    end else begin
      cpuCount   <= cpuCount + 1'b1;
      soundCount <= soundCount + 1'b1;
      nmiCount   <= nmiCount + 1'b1;
    end
  end

  // Sound counter starts on its match value, so skip that first match
  always_ff @(posedge clk) begin
    if (rst) begin
      soundArmed <= 1'b0;
    end else if (soundCount != arcadeIoPkg::soundCount_t'(arcadeIoPkg::soundTickReload)) begin
      soundArmed <= 1'b1;
    end
  end

  always_comb begin
    ticks.cpuTick   = (cpuCount == arcadeIoPkg::cpuCount_t'(arcadeIoPkg::cpuTickReload - 1));
    ticks.soundTick = soundArmed &&
                      (soundCount == arcadeIoPkg::soundCount_t'(arcadeIoPkg::soundTickReload));
    ticks.nmiTick   = (nmiCount == arcadeIoPkg::nmiCount_t'(arcadeIoPkg::nmiTickReload - 1));
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  // Enables are single-cycle pulses
  cpuTickPulse: assert property (@(posedge clk) disable iff (rst)
    ticks.cpuTick |=> !ticks.cpuTick);

  nmiTickPulse: assert property (@(posedge clk) disable iff (rst)
    ticks.nmiTick |=> !ticks.nmiTick);

endmodule

// ==== verilog/nmiTimer.sv ====
`timescale 1ns/1ps

module nmiTimer (
  input  logic                  clk,
  input  logic                  rst,
  input  arcadeIoPkg::tickBus_t ticks,
  output logic                  nmi
);

  arcadeIoPkg::nmiCycle_t nmiCount;

  // One interrupt tick of NMI in every cycle of 14
  always_ff @(posedge clk) begin
    if (rst) begin
      nmiCount <= '0;
      nmi      <= 1'b0;
    end else if (ticks.nmiTick) begin
      nmi <= (nmiCount == arcadeIoPkg::nmiCycle_t'(arcadeIoPkg::nmiAssertCount));
      if (nmiCount == arcadeIoPkg::nmiCycle_t'(arcadeIoPkg::nmiCycleLength - 1)) begin
        nmiCount <= '0;
      end else begin
        nmiCount <= nmiCount + 1'b1;
      end
    end
  end

  // NMI edges line up with the interrupt tick
  nmiOnTick: assert property (@(posedge clk) disable iff (rst)
    $changed(nmi) |-> $past(ticks.nmiTick));

endmodule

// ==== verilog/latchBusPort.sv ====
`timescale 1ns/1ps

module latchBusPort (
  input  logic                   clk,
  input  logic                   rst,
  input  arcadeIoPkg::tickBus_t  ticks,
  input  arcadeIoPkg::gameMode_t mode,
  input  arcadeIoPkg::apbReq_t   apbReq,
  output arcadeIoPkg::apbRsp_t   apbRsp,
  output logic [1:0]             pokeyCs,
  output arcadeIoPkg::latchBus_t latches
);

  logic       accessPhase;
  logic       xferDone;
  logic       bzHit;
  logic       rbHit;
  logic [7:0] readData;

  // True when addr falls in the 16-byte window at base
  function automatic logic inWindow(input logic [15:0] addr, input logic [15:0] base);
    inWindow = (addr[15:arcadeIoPkg::pokeyWindowBits] ==
                base[15:arcadeIoPkg::pokeyWindowBits]);
  endfunction

  ////////////////////////////////////////////////////////////
  // APB handshake
  ////////////////////////////////////////////////////////////
  assign accessPhase = apbReq.psel && apbReq.penable;
  // Access phase waits for the CPU tick
  assign xferDone    = accessPhase && ticks.cpuTick;

  assign bzHit = (apbReq.paddr == arcadeIoPkg::bzLatchAddr);
  assign rbHit = (apbReq.paddr == arcadeIoPkg::rbLatchAddr);

  // Output latches ignore other addresses
  always_ff @(posedge clk) begin
    if (rst) begin
      latches <= '0;
    end else if (xferDone && apbReq.pwrite) begin
      if (bzHit) begin
        latches.bzLatch <= apbReq.pwdata;
      end
      if (rbHit) begin
        latches.rbLatch <= apbReq.pwdata;
      end
    end
  end

  // Readback mux
  always_comb begin
    if (bzHit) begin
      readData = latches.bzLatch;
    end else if (rbHit) begin
      readData = latches.rbLatch;
    end else begin
      readData = '0;
    end
  end

  assign apbRsp.pready = xferDone;
  assign apbRsp.prdata = (apbReq.psel && !apbReq.pwrite) ? readData : 8'h00;

  ////////////////////////////////////////////////////////////
  // POKEY chip selects
  ////////////////////////////////////////////////////////////
  always_comb begin
    pokeyCs = 2'b00;
    if (apbReq.psel) begin
      case (mode)
        arcadeIoPkg::modeBattlezone: begin
          pokeyCs[0] = inWindow(apbReq.paddr, arcadeIoPkg::bzPokeyBase);
        end
        arcadeIoPkg::modeRedBaron: begin
          pokeyCs[0] = inWindow(apbReq.paddr, arcadeIoPkg::rbPokeyBase);
        end
        arcadeIoPkg::modeTempest: begin
          // Tempest is the only board with a second POKEY
          pokeyCs[0] = inWindow(apbReq.paddr, arcadeIoPkg::tempestPokey0Base);
          pokeyCs[1] = inWindow(apbReq.paddr, arcadeIoPkg::tempestPokey1Base);
        end
        default: begin
          pokeyCs = 2'b00;
        end
      endcase
    end
  end

  // Completion only in an access phase that followed a setup phase
  readyInAccess: assert property (@(posedge clk) disable iff (rst)
    apbRsp.pready |-> accessPhase && $past(apbReq.psel));

  tempestOnlyCs1: assert property (@(posedge clk) disable iff (rst)
    (mode != arcadeIoPkg::modeTempest) |-> !pokeyCs[1]);

endmodule

// ==== verilog/discreteSound.sv ====
`timescale 1ns/1ps

module discreteSound (
  input  logic                   clk,
  input  logic                   rst,
  input  arcadeIoPkg::tickBus_t  ticks,
  input  arcadeIoPkg::gameMode_t mode,
  input  arcadeIoPkg::latchBus_t latches,
  output logic [7:0]             jd,
  output logic [7:0]             audioSel,
  output logic                   ampSd
);

  logic [arcadeIoPkg::lfsrWidth-1:0] lfsr;
  logic                              feedback;
  logic                              tone0;
  logic                              tone1;
  logic                              ampOn;

  // Latch bit 5 enables the amplifier
  assign ampOn    = latches.bzLatch[5];
  assign feedback = ~(lfsr[arcadeIoPkg::lfsrTapLow] ^ lfsr[arcadeIoPkg::lfsrTapHigh]);

  ////////////////////////////////////////////////////////////
  // Noise and tone generation
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= '0;
    end else if (ticks.soundTick) begin
      if (!ampOn) begin
        lfsr <= '0;
      end else begin
        lfsr <= {lfsr[arcadeIoPkg::lfsrWidth-2:0], feedback};
      end
    end
  end

  // Tones follow the old LFSR state
  always_ff @(posedge clk) begin
    if (rst) begin
      tone0 <= 1'b0;
      tone1 <= 1'b0;
    end else if (ticks.soundTick) begin
      if (lfsr[arcadeIoPkg::lfsrWidth-1]) begin
        tone0 <= ~tone0;
      end
      if (!(&lfsr[14:11])) begin
        tone1 <= ~tone1;
      end
    end
  end

  // Pins are active low
  always_comb begin
    jd[0] = ~latches.bzLatch[3];
    jd[1] = ~latches.bzLatch[2];
    jd[2] = ~tone0;
    jd[3] = ~latches.bzLatch[1];
    jd[4] = ~latches.bzLatch[0];
    jd[5] = ~tone1;
    // Motor outputs only with the amp on
    if (ampOn) begin
      jd[6] = ~latches.bzLatch[7];
      jd[7] = ~latches.bzLatch[4];
    end else begin
      jd[6] = 1'b1;
      jd[7] = 1'b1;
    end
  end

  assign audioSel = (mode == arcadeIoPkg::modeRedBaron) ? latches.rbLatch : latches.bzLatch;
  assign ampSd    = ampOn;

  // One LFSR step per sound tick
  soundTickPulse: assert property (@(posedge clk) disable iff (rst)
    ticks.soundTick |=> !ticks.soundTick);

endmodule

// ==== verilog/arcadeSoundTop.sv ====
`timescale 1ns/1ps

module arcadeSoundTop (
  input  logic                   clk,
  input  logic                   rst,
  input  arcadeIoPkg::gameMode_t mode,
  input  arcadeIoPkg::apbReq_t   apbReq,
  output arcadeIoPkg::apbRsp_t   apbRsp,
  output logic [1:0]             pokeyCs,
  output logic                   nmi,
  output logic [7:0]             jd,
  output logic [7:0]             audioSel,
  output logic                   ampSd
);

  // Shared enables and latch contents
  arcadeIoPkg::tickBus_t  ticks;
  arcadeIoPkg::latchBus_t latches;

  tickGenerator tickGen (
    .clk   (clk),
    .rst   (rst),
    .ticks (ticks)
  );

  nmiTimer nmiGen (
    .clk   (clk),
    .rst   (rst),
    .ticks (ticks),
    .nmi   (nmi)
  );

  ////////////////////////////////////////////////////////////
  // CPU side
  ////////////////////////////////////////////////////////////
  latchBusPort busPort (
    .clk     (clk),
    .rst     (rst),
    .ticks   (ticks),
    .mode    (mode),
    .apbReq  (apbReq),
    .apbRsp  (apbRsp),
    .pokeyCs (pokeyCs),
    .latches (latches)
  );

  ////////////////////////////////////////////////////////////
  // Sound side
  ////////////////////////////////////////////////////////////
  discreteSound sound (
    .clk      (clk),
    .rst      (rst),
    .ticks    (ticks),
    .mode     (mode),
    .latches  (latches),
    .jd       (jd),
    .audioSel (audioSel),
    .ampSd    (ampSd)
  );

endmodule

// ==== testbench/tbArcadeSound.sv ====
`timescale 1ns/1ps

module tbArcadeSound;

  localparam int halfPeriod  = 10;
  localparam int sampleDelay = 5;
  localparam int resetCycles = 8;
  localparam int numVectors  = 20;
  localparam int xferLimit   = 16;
  localparam int tickLimit   = 8300;
  localparam int nmiLimit    = 240000;
  localparam int soundTicks  = 40;

  logic                   clk;
  logic                   rst;
  arcadeIoPkg::gameMode_t mode;
  arcadeIoPkg::apbReq_t   apbReq;
  arcadeIoPkg::apbRsp_t   apbRsp;
  logic [1:0]             pokeyCs;
  logic                   nmi;
  logic [7:0]             jd;
  logic [7:0]             audioSel;
  logic                   ampSd;

  logic [39:0] vectors [0:numVectors-1];
  int          cycleCount;
  int          errorCount;
  int          testCount;
  int          failedTests;
  int          testStartErrors;
  integer      seed;
  logic [7:0]  bzModel;
  logic [7:0]  rbModel;
  logic [15:0] refLfsr;
  logic        refTone0;
  logic        refTone1;

  arcadeSoundTop UUT (
    .clk      (clk),
    .rst      (rst),
    .mode     (mode),
    .apbReq   (apbReq),
    .apbRsp   (apbRsp),
    .pokeyCs  (pokeyCs),
    .nmi      (nmi),
    .jd       (jd),
    .audioSel (audioSel),
    .ampSd    (ampSd)
  );

  always #(halfPeriod) clk = ~clk;

  // Posedges since reset release
  always @(posedge clk) begin
    if (rst) begin
      cycleCount <= 0;
    end else begin
      cycleCount <= cycleCount + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////
  task automatic reportMismatch(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
    $display("error: %s expected %h got %h", name, expected, actual);
    errorCount++;
  endtask

  task automatic reportProblem(input string what);
    $display("%s", what);
    errorCount++;
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (errorCount == testStartErrors) begin
      $display("test %0d %s: passed", testCount, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", testCount, name,
               errorCount - testStartErrors);
      failedTests++;
    end
    testStartErrors = errorCount;
  endtask

  ////////////////////////////////////////////////////////////
  // APB master
  ////////////////////////////////////////////////////////////
  task automatic apbTransfer(input logic write, input logic [15:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata);
    int   waited;
    logic done;
    @(negedge clk);
    apbReq.psel    = 1'b1;
    apbReq.penable = 1'b0;
    apbReq.pwrite  = write;
    apbReq.paddr   = addr;
    apbReq.pwdata  = wdata;
    @(negedge clk);
    apbReq.penable = 1'b1;
    waited = 0;
    done   = 1'b0;
    rdata  = 8'h00;
    // Sample pready mid-cycle before the completing edge
    while (!done && waited < xferLimit) begin
      #(sampleDelay);
      if (apbRsp.pready) begin
        done  = 1'b1;
        rdata = apbRsp.prdata;
      end
      @(negedge clk);
      waited++;
    end
    apbReq.psel    = 1'b0;
    apbReq.penable = 1'b0;
    if (!done) begin
      reportProblem($sformatf("timeout: no pready within %0d cycles at address %h",
                              xferLimit, addr));
    end
  endtask

  task automatic writeLatch(input logic [15:0] addr, input logic [7:0] data);
    logic [7:0] unused;
    apbTransfer(1'b1, addr, data, unused);
    if (addr == arcadeIoPkg::bzLatchAddr) begin
      bzModel = data;
    end
    if (addr == arcadeIoPkg::rbLatchAddr) begin
      rbModel = data;
    end
  endtask

  task automatic readCheck(input logic [15:0] addr, input logic [7:0] expected);
    logic [7:0] rdata;
    apbTransfer(1'b0, addr, 8'h00, rdata);
    if (rdata !== expected) reportMismatch("prdata", expected, rdata);
  endtask

  ////////////////////////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////////////////////////
  // Active-low pins from bzLatch with the tone pins masked out
  function automatic logic [7:0] expectedPins(input logic [7:0] bz);
    logic [7:0] pins;
    pins    = 8'h00;
    pins[0] = ~bz[3];
    pins[1] = ~bz[2];
    pins[3] = ~bz[1];
    pins[4] = ~bz[0];
    pins[6] = bz[5] ? ~bz[7] : 1'b1;
    pins[7] = bz[5] ? ~bz[4] : 1'b1;
    return pins;
  endfunction

  task automatic stepSoundModel(input logic ampOn);
    logic [15:0] prev;
    prev = refLfsr;
    if (ampOn) begin
      refLfsr = {prev[14:0], prev[3] ~^ prev[14]};
    end else begin
      refLfsr = 16'h0000;
    end
    if (prev[15]) refTone0 = ~refTone0;
    if (prev[14:11] != 4'hF) refTone1 = ~refTone1;
  endtask

  // Step one negedge at a time until the posedge count reaches target
  task automatic waitForCycle(input int target);
    int waited;
    waited = 0;
    while (cycleCount < target && waited < tickLimit) begin
      @(negedge clk);
      waited++;
    end
    if (cycleCount != target) begin
      reportProblem($sformatf("timeout: sound tick cycle %0d was not reached", target));
    end
  endtask

  task automatic soundTickCheck(input int tick);
    logic [7:0] expTones;
    waitForCycle(arcadeIoPkg::soundTickPeriod * tick + 1);
    stepSoundModel(bzModel[5]);
    expTones = {6'b0, ~refTone1, ~refTone0};
    if ({6'b0, jd[5], jd[2]} !== expTones) begin
      reportMismatch("jd[5,2]", expTones, {6'b0, jd[5], jd[2]});
    end
  endtask

  task automatic waitForNmi(input logic level, output int when);
    int waited;
    waited = 0;
    while (nmi !== level && waited < nmiLimit) begin
      @(negedge clk);
      waited++;
    end
    when = cycleCount;
    if (nmi !== level) reportProblem("timeout: nmi did not reach the expected level");
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [39:0] vec;
    logic [31:0] rnd;
    logic [7:0]  bzValue;
    logic [7:0]  expSel;
    int          riseA;
    int          fallA;
    int          riseB;
    clk = 1'b0;
    rst = 1'b1;
    mode = arcadeIoPkg::modeBattlezone;
    apbReq = '0;
    seed = 84429;
    errorCount = 0;
    testCount = 0;
    failedTests = 0;
    testStartErrors = 0;
    bzModel = 8'h00;
    rbModel = 8'h00;
    refLfsr = 16'h0000;
    refTone0 = 1'b0;
    refTone1 = 1'b0;
    $readmemh("testbench/arcadeSoundVectors.txt", vectors);
    if ($isunknown(vectors[numVectors-1])) reportProblem("vector file is short or unreadable");
    repeat (resetCycles) @(negedge clk);
    rst = 1'b0;

    @(negedge clk);
    if (jd !== 8'hFF) reportMismatch("jd", 8'hFF, jd);
    if (ampSd !== 1'b0) reportMismatch("ampSd", 8'h00, {7'b0, ampSd});
    if (nmi !== 1'b0) reportMismatch("nmi", 8'h00, {7'b0, nmi});
    if (pokeyCs !== 2'b00) reportMismatch("pokeyCs", 8'h00, {6'b0, pokeyCs});
    if (audioSel !== 8'h00) reportMismatch("audioSel", 8'h00, audioSel);
    finishTest("after reset");

    for (int v = 0; v < numVectors; v++) begin
      vec = vectors[v];
      if (vec[39:36] == 4'h0) writeLatch(vec[31:16], vec[15:8]);
      if (vec[39:36] == 4'h1) readCheck(vec[31:16], vec[7:0]);
    end
    // Odd addresses never hit a latch
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      writeLatch(arcadeIoPkg::bzLatchAddr, rnd[7:0]);
      writeLatch(arcadeIoPkg::rbLatchAddr, rnd[15:8]);
      rnd = $random(seed);
      writeLatch({rnd[31:17], 1'b1}, rnd[7:0]);
      readCheck({rnd[31:17], 1'b1}, 8'h00);
      readCheck(arcadeIoPkg::bzLatchAddr, bzModel);
      readCheck(arcadeIoPkg::rbLatchAddr, rbModel);
    end
    finishTest("apb writes and reads");

    for (int v = 0; v < numVectors; v++) begin
      vec = vectors[v];
      if (vec[39:36] == 4'h2) begin
        @(negedge clk);
        mode = arcadeIoPkg::gameMode_t'(vec[33:32]);
        apbReq.psel = 1'b1;
        apbReq.paddr = vec[31:16];
        #(sampleDelay);
        if (pokeyCs !== vec[1:0]) reportMismatch("pokeyCs", vec[7:0], {6'b0, pokeyCs});
      end
    end
    @(negedge clk);
    apbReq = '0;
    mode = arcadeIoPkg::modeBattlezone;
    finishTest("chip selects");

    // Motor gating off, then on with each motor pin low in turn
    for (int i = 0; i < 3; i++) begin
      case (i)
        0: bzValue = 8'h9A;
        1: bzValue = 8'hA4;
        default: bzValue = 8'h35;
      endcase
      rnd = $random(seed);
      writeLatch(arcadeIoPkg::bzLatchAddr, bzValue);
      writeLatch(arcadeIoPkg::rbLatchAddr, rnd[7:0]);
      for (int m = 0; m < 3; m++) begin
        @(negedge clk);
        mode = arcadeIoPkg::gameMode_t'(m[1:0]);
        #(sampleDelay);
        expSel = (m == 1) ? rbModel : bzModel;
        if (audioSel !== expSel) reportMismatch("audioSel", expSel, audioSel);
        if ((jd & 8'hDB) !== expectedPins(bzModel)) begin
          reportMismatch("jd", expectedPins(bzModel), jd & 8'hDB);
        end
        if (ampSd !== bzModel[5]) reportMismatch("ampSd", {7'b0, bzModel[5]}, {7'b0, ampSd});
      end
    end
    @(negedge clk);
    mode = arcadeIoPkg::modeBattlezone;
    finishTest("latch outputs");

    for (int k = 1; k <= soundTicks; k++) begin
      soundTickCheck(k);
    end
    writeLatch(arcadeIoPkg::bzLatchAddr, bzModel & 8'hDF);
    for (int k = soundTicks + 1; k <= soundTicks + 3; k++) begin
      soundTickCheck(k);
    end
    finishTest("discrete sound");

    waitForNmi(1'b0, riseA);
    waitForNmi(1'b1, riseA);
    waitForNmi(1'b0, fallA);
    waitForNmi(1'b1, riseB);
    if (fallA - riseA != 16384) begin
      $display("error: nmi high cycles expected %h got %h", 16384, fallA - riseA);
      errorCount++;
    end
    if (riseB - riseA != 229376) begin
      $display("error: nmi period cycles expected %h got %h", 229376, riseB - riseA);
      errorCount++;
    end
    finishTest("nmi timing");

    $display("tests run %0d, tests failed %0d, errors %0d", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/arcadeSoundVectors.txt ====
// op_mode_addr_data_expected: op 0 write, 1 read, 2 chip-select decode
// mode 0 Battlezone, 1 Red Baron, 2 Tempest; expected is read data or pokeyCs
0_0_1840_A5_00
0_0_1808_3C_00
1_0_1840_00_A5
1_0_1808_00_3C
0_0_1841_FF_00
1_0_1840_00_A5
1_0_1808_00_3C
1_0_0000_00_00
2_0_181F_00_00
2_0_1820_00_01
2_0_182F_00_01
2_0_1830_00_00
2_1_180F_00_00
2_1_1810_00_01
2_1_181F_00_01
2_2_60BF_00_00
2_2_60C0_00_01
2_2_60CF_00_01
2_2_60D0_00_02
2_2_60DF_00_02

// ==== sources.f ====
verilog/arcadeIoPkg.sv
verilog/tickGenerator.sv
verilog/nmiTimer.sv
verilog/latchBusPort.sv
verilog/discreteSound.sv
verilog/arcadeSoundTop.sv
testbench/tbArcadeSound.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tbArcadeSound -o simArcadeSound

./obj_dir/simArcadeSound > sim.log 2>&1 || true
cat sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
  echo "Result: pass"
else
  echo "Result: fail"
  exit 1
fi
